//--- post_cases.txt
// per line, all hex: length, keep flag (1 = reuse the buffer of the run before),
// accumulator values, then the expected pooled results; a length of 00 ends the list
08 0 05 f6 80 7f 00 ff 12 2c 05 7f 00 2c
06 0 ff 80 c3 f0 9c fe 00 00 00
04 1 ff 80 c3 f0 00 00
10 0 7f 00 01 02 10 0f 80 81 40 c0 3c 3d 00 00 fe 01 7f 02 10 00 40 3d 00 01
02 1 7f 00 7f
12 0 01 01 7e 7f 80 00 ff 01 20 1f 64 9c 33 33 00 7f 08 f8 01 7f 00 01 20 64 33 7f 08
00

//--- sim.f
post_pkg.sv
post_buffer.sv
post_apb_regs.sv
post_ctrl_fsm.sv
post_index_counter.sv
relu_act.sv
max_pool_pair.sv
post_top.sv
post_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the output stage testbench
verilator --binary --timing -Wno-fatal -f sim.f --top-module post_tb -o post_sim || exit 1
./obj_dir/post_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

//--- post_tb.sv
// output stage testbench
`timescale 1ns/1ps
`default_nettype none

module post_tb;
    import post_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    logic [31:0] cases_mem [1024];
    bit          cases_loaded;
    logic [31:0] rd;
    int          pos;
    int          len;
    int          keep;
    int          case_no;

    post_top #(
        .DEPTH (64)
    ) i_post_top (
        .clk       (clk),
        .rst       (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    // the slave never stalls and never flags an error
    task automatic check_response(input logic ready, input logic slverr, input string what);
        if (ready !== 1'b1 || slverr !== 1'b0) begin
            $display("CHECK FAILED at %0t: %s got pready %b pslverr %b, expected 1 and 0",
                     $time, what, ready, slverr);
            report_failure();
        end
    endtask

    // setup on one falling edge, access on the next
    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        check_response(pready, pslverr, "write");
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        // prdata is settled by the end of the access phase
        data    = prdata;
        check_response(pready, pslverr, "read");
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_word(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s read %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    // busy stands for both READ and DRAIN
    task automatic check_status(input logic [31:0] got, input ctrl_state_t exp);
        logic [31:0] want;
        if (exp == DONE) begin
            want = 32'd2;
        end else if (exp == IDLE) begin
            want = 32'd0;
        end else begin
            want = 32'd1;
        end
        if (got !== want) begin
            $display("CHECK FAILED at %0t: status %h, expected %h for %s",
                     $time, got, want, exp.name());
            report_failure();
        end
    endtask

    // run budget over all cases in the file
    function automatic int total_cycles();
        int p;
        int n;
        int total;
        p = 0;
        total = 0;
        while (cases_mem[p] != 0) begin
            n = int'(cases_mem[p]);
            total += n * 4 + 200;
            p += 2 + n + n / 2;
        end
        return total;
    endfunction

    initial begin
        int limit;
        wait (cases_loaded);
        // extra cycles for reset and the first status read
        limit = total_cycles() + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        report_failure();
    end

    initial begin
        rst     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        $readmemh("post_cases.txt", cases_mem);
        if ($isunknown(cases_mem[0])) begin
            $display("the cases file post_cases.txt is missing or empty");
            report_failure();
        end
        cases_loaded = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b1;

        apb_read(REG_STATUS, rd);
        check_status(rd, IDLE);

        pos     = 0;
        case_no = 0;
        while (cases_mem[pos] != 0) begin
            len  = int'(cases_mem[pos]);
            keep = int'(cases_mem[pos + 1]);
            pos += 2;
            if (len < 2 || len > 64 || len % 2 != 0) begin
                $display("case %0d has a bad length of %0d", case_no, len);
                report_failure();
            end
            apb_write(REG_LEN, 32'(len));
            // keep means the buffer still holds the last run's words
            if (keep == 0) begin
                for (int i = 0; i < len; i++) begin
                    apb_write(ACC_BASE + APB_ADDR_W'(4 * i), cases_mem[pos + i]);
                end
            end
            pos += len;
            apb_write(REG_CTRL, 32'h1);
            // host write early in the run, while the read index is still low
            apb_write(ACC_BASE, 32'h55);
            apb_read(REG_STATUS, rd);
            // a two-element run has already finished by this read
            if (len == 2) begin
                check_status(rd, DONE);
            end else begin
                check_status(rd, READ);
            end
            do begin
                apb_read(REG_STATUS, rd);
            end while (rd[0] === 1'b1);
            check_status(rd, DONE);
            for (int j = 0; j < len / 2; j++) begin
                apb_read(RES_BASE + APB_ADDR_W'(4 * j), rd);
                check_word(data_t'(rd[DATA_W-1:0]), data_t'(cases_mem[pos + j][DATA_W-1:0]),
                           $sformatf("case %0d result %0d", case_no, j));
            end
            pos += len / 2;
            case_no++;
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- post_top.sv
// output stage top level
`timescale 1ns/1ps
`default_nettype none

module post_top #(
    parameter int DEPTH = 64
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             psel_i,
    input  wire                             penable_i,
    input  wire                             pwrite_i,
    input  wire  [post_pkg::APB_ADDR_W-1:0] paddr_i,
    input  wire  [31:0]                     pwdata_i,
    output logic [31:0]                     prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o
);
    import post_pkg::*;

    logic             start;
    logic             busy;
    logic             done;
    logic             rd_en;
    logic             cnt_clr;
    logic             idx_last;
    logic             beat_valid;
    logic             beat_last;
    logic             acc_we;
    logic             act_valid;
    logic             pool_valid;
    logic             pool_done;
    logic [IDX_W:0]   len;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] apb_acc_addr;
    logic [IDX_W-1:0] apb_res_addr;
    logic [IDX_W-1:0] acc_addr;
    logic [IDX_W-1:0] res_addr;
    data_t            acc_wdata;
    data_t            acc_rdata;
    data_t            res_rdata;
    act_beat_t        acc_beat;
    act_beat_t        act_beat;
    act_beat_t        pool_beat;

    post_apb_regs i_post_apb_regs (
        .clk         (clk),
        .rst         (rst),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .busy_i      (busy),
        .done_i      (done),
        .res_rdata_i (res_rdata),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .start_o     (start),
        .len_o       (len),
        .acc_we_o    (acc_we),
        .acc_addr_o  (apb_acc_addr),
        .acc_wdata_o (acc_wdata),
        .res_addr_o  (apb_res_addr)
    );

    post_ctrl_fsm i_post_ctrl_fsm (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start),
        .len_i        (len),
        .idx_last_i   (idx_last),
        .pool_done_i  (pool_done),
        .busy_o       (busy),
        .done_o       (done),
        .rd_en_o      (rd_en),
        .cnt_clr_o    (cnt_clr),
        .beat_valid_o (beat_valid),
        .beat_last_o  (beat_last)
    );

    post_index_counter #(
        .DEPTH (DEPTH)
    ) i_post_index_counter (
        .clk    (clk),
        .rst    (rst),
        .clr_i  (cnt_clr),
        .en_i   (rd_en),
        .len_i  (len),
        .idx_o  (rd_idx),
        .last_o (idx_last)
    );

    // the host owns the accumulator buffer between runs
    assign acc_addr = busy ? rd_idx : apb_acc_addr;

    post_buffer #(
        .DEPTH  (DEPTH),
        .word_t (data_t)
    ) i_acc_buffer (
        .clk     (clk),
        .we_i    (acc_we),
        .addr_i  (acc_addr),
        .wdata_i (acc_wdata),
        .rdata_o (acc_rdata)
    );

    // counter has moved one step past the word now on the RAM output
    assign acc_beat.data = acc_rdata;
    assign acc_beat.idx  = rd_idx - 1'b1;
    assign acc_beat.last = beat_last;

    relu_act i_relu_act (
        .clk     (clk),
        .rst     (rst),
        .valid_i (beat_valid),
        .beat_i  (acc_beat),
        .valid_o (act_valid),
        .beat_o  (act_beat)
    );

    max_pool_pair i_max_pool_pair (
        .clk     (clk),
        .rst     (rst),
        .valid_i (act_valid),
        .beat_i  (act_beat),
        .valid_o (pool_valid),
        .beat_o  (pool_beat),
        .done_o  (pool_done)
    );

    // pooled writes take the port, host reads otherwise
    assign res_addr = pool_valid ? pool_beat.idx : apb_res_addr;

    post_buffer #(
        .DEPTH  (DEPTH),
        .word_t (data_t)
    ) i_res_buffer (
        .clk     (clk),
        .we_i    (pool_valid),
        .addr_i  (res_addr),
        .wdata_i (pool_beat.data),
        .rdata_o (res_rdata)
    );

endmodule

`default_nettype wire

//--- max_pool_pair.sv
// 1x2 max pool
`timescale 1ns/1ps
`default_nettype none

module max_pool_pair (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      valid_i,
    input  wire  post_pkg::act_beat_t beat_i,
    output logic                     valid_o,
    output post_pkg::act_beat_t      beat_o,
    output logic                     done_o
);
    import post_pkg::*;

    data_t held;
    data_t larger;
    logic  odd;

    assign odd = beat_i.idx[0];

    // signed compare of the pair
    assign larger = ($signed(beat_i.data) > $signed(held)) ? beat_i.data : held;

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & odd;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && !odd) begin
            held <= beat_i.data;
        end
        if (valid_i && odd) begin
            beat_o.data <= larger;
            beat_o.idx  <= {1'b0, beat_i.idx[IDX_W-1:1]};
            beat_o.last <= beat_i.last;
        end
    end

    // high with the final pooled write
    assign done_o = valid_o & beat_o.last;

endmodule

`default_nettype wire

//--- relu_act.sv
// ReLU activation stage
`timescale 1ns/1ps
`default_nettype none

module relu_act (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      valid_i,
    input  wire  post_pkg::act_beat_t beat_i,
    output logic                     valid_o,
    output post_pkg::act_beat_t      beat_o
);
    import post_pkg::*;

    data_t clamped;

    // negatives go to zero, zero and positives pass through
    always_comb begin
        if (beat_i.data[DATA_W-1]) begin
            clamped = '0;
        end else begin
            clamped = beat_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload follows valid, idx and last ride along
    always_ff @(posedge clk) begin
        if (valid_i) begin
            beat_o.data <= clamped;
            beat_o.idx  <= beat_i.idx;
            beat_o.last <= beat_i.last;
        end
    end

endmodule

`default_nettype wire

//--- post_index_counter.sv
// read index counter
`timescale 1ns/1ps
`default_nettype none

module post_index_counter #(
    parameter int DEPTH = 64
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         clr_i,
    input  wire                         en_i,
    input  wire  [post_pkg::IDX_W:0]    len_i,
    output logic [post_pkg::IDX_W-1:0]  idx_o,
    output logic                        last_o
);
    import post_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst) begin
            idx_o <= '0;
        end else if (clr_i) begin
            idx_o <= '0;
        end else if (en_i) begin
            // wraps at the buffer end
            if (idx_o == IDX_W'(DEPTH - 1)) begin
                idx_o <= '0;
            end else begin
                idx_o <= idx_o + 1'b1;
            end
        end
    end

    // terminal read of this run
    assign last_o = {1'b0, idx_o} == (len_i - 1'b1);

endmodule

`default_nettype wire

//--- post_ctrl_fsm.sv
// run controller
`timescale 1ns/1ps
`default_nettype none

module post_ctrl_fsm (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start_i,
    input  wire  [post_pkg::IDX_W:0]  len_i,
    input  wire                       idx_last_i,
    input  wire                       pool_done_i,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      rd_en_o,
    output logic                      cnt_clr_o,
    output logic                      beat_valid_o,
    output logic                      beat_last_o
);
    import post_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_n;
    logic        go;

    // starts only between runs and with a nonzero length
    assign go = start_i & (len_i != '0) & ((state == IDLE) | (state == DONE));

    always_comb begin
        state_n = state;
        case (state)
            IDLE, DONE: begin
                if (go) begin
                    state_n = READ;
                end
            end
            READ: begin
                if (idx_last_i) begin
                    state_n = DRAIN;
                end
            end
            DRAIN: begin
                // wait for the last pooled word to land
                if (pool_done_i) begin
                    state_n = DONE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= IDLE;
            beat_valid_o <= 1'b0;
            beat_last_o  <= 1'b0;
        end else begin
            state        <= state_n;
            // beat flags line up with the RAM read data
            beat_valid_o <= rd_en_o;
            beat_last_o  <= rd_en_o & idx_last_i;
        end
    end

    assign rd_en_o   = state == READ;
    assign cnt_clr_o = go;
    assign busy_o    = (state == READ) | (state == DRAIN);
    assign done_o    = state == DONE;

endmodule

`default_nettype wire

//--- post_apb_regs.sv
// APB host port and control registers
`timescale 1ns/1ps
`default_nettype none

module post_apb_regs (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             psel_i,
    input  wire                             penable_i,
    input  wire                             pwrite_i,
    input  wire  [post_pkg::APB_ADDR_W-1:0] paddr_i,
    input  wire  [31:0]                     pwdata_i,
    input  wire                             busy_i,
    input  wire                             done_i,
    input  wire  post_pkg::data_t           res_rdata_i,
    output logic [31:0]                     prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic                            start_o,
    output logic [post_pkg::IDX_W:0]        len_o,
    output logic                            acc_we_o,
    output logic [post_pkg::IDX_W-1:0]      acc_addr_o,
    output post_pkg::data_t                 acc_wdata_o,
    output logic [post_pkg::IDX_W-1:0]      res_addr_o
);
    import post_pkg::*;

    logic access;
    logic in_acc;
    logic in_res;

    assign access = psel_i & penable_i;
    assign in_acc = paddr_i[APB_ADDR_W-1:8] == ACC_BASE[APB_ADDR_W-1:8];
    assign in_res = paddr_i[APB_ADDR_W-1:8] == RES_BASE[APB_ADDR_W-1:8];

    always_ff @(posedge clk) begin
        if (!rst) begin
            start_o <= 1'b0;
            len_o   <= '0;
        end else begin
            // one-cycle pulse, the FSM drops it while busy
            start_o <= access & pwrite_i & (paddr_i == REG_CTRL) & pwdata_i[0];
            if (access && pwrite_i && paddr_i == REG_LEN) begin
                len_o <= pwdata_i[IDX_W:0];
            end
        end
    end

    // host loads the accumulator buffer only between runs
    assign acc_we_o    = access & pwrite_i & in_acc & ~busy_i;
    assign acc_addr_o  = paddr_i[2 +: IDX_W];
    assign acc_wdata_o = pwdata_i[DATA_W-1:0];

    // address is live from setup so the RAM word is ready in access
    assign res_addr_o  = paddr_i[2 +: IDX_W];

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (paddr_i == REG_STATUS) begin
                prdata_o = {30'b0, done_i, busy_i};
            end else if (paddr_i == REG_LEN) begin
                prdata_o = {{(31-IDX_W){1'b0}}, len_o};
            end else if (in_res) begin
                prdata_o = {{(32-DATA_W){res_rdata_i[DATA_W-1]}}, res_rdata_i};
            end
        end
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = 1'b0;

endmodule

`default_nettype wire

//--- post_buffer.sv
// single-port buffer RAM
`timescale 1ns/1ps
`default_nettype none

module post_buffer #(
    parameter int  DEPTH  = 64,
    parameter type word_t = logic [7:0]
) (
    input  wire                       clk,
    input  wire                       we_i,
    input  wire  [$clog2(DEPTH)-1:0]  addr_i,
    input  wire  word_t               wdata_i,
    output word_t                     rdata_o
);

    word_t mem [DEPTH];

    // write first into the array, read returns the old word
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- post_pkg.sv
// output stage shared definitions
`default_nettype none

package post_pkg;

    localparam int DATA_W     = 8;
    localparam int IDX_W      = 6;
    localparam int APB_ADDR_W = 12;

    // host register map
    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 12'h000;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 12'h004;
    localparam logic [APB_ADDR_W-1:0] REG_LEN    = 12'h008;

    // one 32-bit word per element, 64 elements per window
    localparam logic [APB_ADDR_W-1:0] ACC_BASE   = 12'h100;
    localparam logic [APB_ADDR_W-1:0] RES_BASE   = 12'h200;

    // accumulator and result values, two's complement
    typedef logic signed [DATA_W-1:0] data_t;

    // beat of the internal stream, valid travels beside it
    typedef struct packed {
        data_t            data;
        logic [IDX_W-1:0] idx;
        logic             last;
    } act_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire
